// ==== src/csr_index_pkg.sv ====
// CSR index engine definitions
`default_nettype none

package csr_index_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int PAYLOAD_W  = 64;
    localparam int INDEX_W    = 24;
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int WORD_BYTES = 4;

    // FIFO sizing used by the top level
    localparam int FIFO_DEPTH  = 16;
    localparam int PROG_THRESH = 8;

    // Bit positions in a 64-bit packet
    localparam int DEST_BIT = 63;
    localparam int TAG_HI   = 55;
    localparam int TAG_LO   = 32;
    localparam int LOW_HI   = 31;
    localparam int LOW_LO   = 0;

    // Destination bit values
    localparam logic DEST_CONFIG    = 1'b0;
    localparam logic DEST_GENERATOR = 1'b1;

    // Configuration field codes
    localparam logic [2:0] CFG_START_INDEX = 3'd0;
    localparam logic [2:0] CFG_INDEX_COUNT = 3'd1;
    localparam logic [2:0] CFG_BASE_ADDR   = 3'd2;

    // ------------------------------
    // Memory response views
    // ------------------------------
    typedef struct packed {
        logic              dest;
        logic [2:0]        field;
        logic [27:0]       reserved;
        logic [DATA_W-1:0] value;
    } cfg_word_t;

    typedef struct packed {
        logic               dest;
        logic [6:0]         reserved;
        logic [INDEX_W-1:0] index;
        logic [DATA_W-1:0]  data;
    } data_word_t;

    // Same 64 bits, dest bit shared by both views
    typedef union packed {
        cfg_word_t  cfg;
        data_word_t data;
    } response_word_t;

endpackage

`default_nettype wire

// ==== src/packet_fifo.sv ====
// Synchronous FWFT packet FIFO
`default_nettype none

module packet_fifo import csr_index_pkg::*; #(
    parameter int DEPTH  = 16,
    parameter int THRESH = 8
) (
    input  wire logic                 ap_clk,
    input  wire logic                 areset_csr_engine,
    input  wire logic                 wr_en_i,
    input  wire logic [PAYLOAD_W-1:0] din_i,
    input  wire logic                 rd_en_i,
    output logic      [PAYLOAD_W-1:0] dout_o,
    output logic                      valid_o,
    output logic                      empty_o,
    output logic                      full_o,
    output logic                      prog_full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [PAYLOAD_W-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0]     wr_ptr_q;
    logic [PTR_W-1:0]     rd_ptr_q;
    logic [CNT_W-1:0]     count_q;

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge ap_clk) begin
        if (wr_en_i) begin
            mem_q[wr_ptr_q] <= din_i;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (rd_en_i) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({wr_en_i, rd_en_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Head word is visible without a read
    assign dout_o      = mem_q[rd_ptr_q];
    assign empty_o     = (count_q == '0);
    assign valid_o     = !empty_o;
    assign full_o      = (count_q == CNT_W'(DEPTH));
    assign prog_full_o = (count_q >= CNT_W'(THRESH));

    a_no_push_full: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        full_o |-> !wr_en_i);

    a_no_pop_empty: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        empty_o |-> !rd_en_i);

endmodule

`default_nettype wire

// ==== src/response_router.sv ====
// Response destination router
`default_nettype none

module response_router import csr_index_pkg::*; (
    input  wire logic            ap_clk,
    input  wire logic            areset_csr_engine,
    input  wire logic            fifo_valid_i,
    input  wire response_word_t  fifo_word_i,
    output logic                 fifo_pop_o,
    output logic                 cfg_valid_o,
    output cfg_word_t            cfg_word_o,
    output logic                 gen_valid_o,
    output data_word_t           gen_word_o,
    input  wire logic            gen_accept_i
);

    logic dest;
    logic gen_free;

    assign dest = fifo_word_i[DEST_BIT];

    // Config slot empties every cycle and generator slot only on accept
    assign gen_free   = !gen_valid_o || gen_accept_i;
    assign fifo_pop_o = fifo_valid_i && ((dest == DEST_CONFIG) || gen_free);

    // ------------------------------
    // Holding stages
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            cfg_valid_o <= 1'b0;
            gen_valid_o <= 1'b0;
        end else begin
            cfg_valid_o <= fifo_pop_o && (dest == DEST_CONFIG);
            if (fifo_pop_o && (dest == DEST_GENERATOR)) begin
                gen_valid_o <= 1'b1;
            end else if (gen_accept_i) begin
                gen_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (fifo_pop_o && (dest == DEST_CONFIG)) begin
            cfg_word_o <= fifo_word_i.cfg;
        end
        if (fifo_pop_o && (dest == DEST_GENERATOR)) begin
            gen_word_o <= fifo_word_i.data;
        end
    end

    // A stalled generator word stays in its slot
    a_gen_hold: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        gen_valid_o && !gen_accept_i |=> gen_valid_o && $stable(gen_word_o));

endmodule

`default_nettype wire

// ==== src/csr_index_config.sv ====
// CSR index run configuration
`default_nettype none

module csr_index_config import csr_index_pkg::*; (
    input  wire logic             ap_clk,
    input  wire logic             areset_csr_engine,
    input  wire logic             cfg_valid_i,
    input  wire cfg_word_t        cfg_word_i,
    output logic [INDEX_W-1:0]    start_index_o,
    output logic [INDEX_W-1:0]    index_count_o,
    output logic [ADDR_W-1:0]     base_addr_o,
    output logic                  config_ready_o
);

    // One bit per field, in code order
    logic [2:0] seen_q;

    // ------------------------------
    // Field capture
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (cfg_valid_i) begin
            case (cfg_word_i.field)
                CFG_START_INDEX: start_index_o <= cfg_word_i.value[INDEX_W-1:0];
                CFG_INDEX_COUNT: index_count_o <= cfg_word_i.value[INDEX_W-1:0];
                CFG_BASE_ADDR:   base_addr_o   <= cfg_word_i.value[ADDR_W-1:0];
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            seen_q <= '0;
        end else if (cfg_valid_i) begin
            case (cfg_word_i.field)
                CFG_START_INDEX: seen_q[0] <= 1'b1;
                CFG_INDEX_COUNT: seen_q[1] <= 1'b1;
                CFG_BASE_ADDR:   seen_q[2] <= 1'b1;
                // Unknown codes leave everything as is
                default:         seen_q    <= seen_q;
            endcase
        end
    end

    // Sticky once all three fields arrived
    assign config_ready_o = &seen_q;

endmodule

`default_nettype wire

// ==== src/csr_index_generator.sv ====
// CSR index request generator
`default_nettype none

module csr_index_generator import csr_index_pkg::*; (
    input  wire logic                 ap_clk,
    input  wire logic                 areset_csr_engine,
    input  wire logic                 start_i,
    input  wire logic                 config_ready_i,
    input  wire logic [INDEX_W-1:0]   start_index_i,
    input  wire logic [INDEX_W-1:0]   index_count_i,
    input  wire logic [ADDR_W-1:0]    base_addr_i,
    input  wire logic                 req_prog_full_i,
    output logic                      req_push_o,
    output logic      [PAYLOAD_W-1:0] req_payload_o,
    input  wire logic                 gen_valid_i,
    input  wire data_word_t           gen_word_i,
    output logic                      gen_accept_o,
    input  wire logic                 eng_prog_full_i,
    output logic                      eng_push_o,
    output logic      [PAYLOAD_W-1:0] eng_payload_o,
    output logic                      done_o
);

    logic               running_q;
    logic [INDEX_W-1:0] issued_q;
    logic [INDEX_W-1:0] received_q;
    logic [INDEX_W-1:0] start_q;
    logic [INDEX_W-1:0] count_q;
    logic [ADDR_W-1:0]  base_q;
    logic               launch;
    logic               take;
    logic               last_take;
    logic [INDEX_W-1:0] req_index;
    logic [ADDR_W-1:0]  req_addr;

    // Starts while busy or unconfigured are dropped
    assign launch = !running_q && start_i && config_ready_i;

    // ------------------------------
    // Request issue
    // ------------------------------
    assign req_index  = start_q + issued_q;
    assign req_addr   = base_q + ADDR_W'(req_index) * ADDR_W'(WORD_BYTES);
    assign req_push_o = running_q && (issued_q != count_q) && !req_prog_full_i;

    always_comb begin
        req_payload_o                = '0;
        req_payload_o[TAG_HI:TAG_LO] = req_index;
        req_payload_o[LOW_HI:LOW_LO] = req_addr;
    end

    // ------------------------------
    // Response forwarding
    // ------------------------------
    assign gen_accept_o = !eng_prog_full_i;
    assign take         = gen_valid_i && gen_accept_o;
    assign eng_push_o   = take;
    assign last_take    = take && (received_q == count_q - 1'b1);

    always_comb begin
        eng_payload_o                = '0;
        eng_payload_o[TAG_HI:TAG_LO] = gen_word_i.index;
        eng_payload_o[LOW_HI:LOW_LO] = gen_word_i.data;
    end

    // Run fields held for the whole run
    always_ff @(posedge ap_clk) begin
        if (launch) begin
            start_q <= start_index_i;
            count_q <= index_count_i;
            base_q  <= base_addr_i;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            running_q  <= 1'b0;
            issued_q   <= '0;
            received_q <= '0;
        end else if (launch) begin
            // Zero count stays idle, so done never drops
            running_q  <= (index_count_i != '0);
            issued_q   <= '0;
            received_q <= '0;
        end else if (running_q) begin
            if (req_push_o) begin
                issued_q <= issued_q + 1'b1;
            end
            if (take) begin
                received_q <= received_q + 1'b1;
            end
            if (last_take) begin
                running_q <= 1'b0;
            end
        end
    end

    assign done_o = !running_q;

    // Data words only answer requests of the active run
    a_no_data_idle: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        take |-> running_q);

endmodule

`default_nettype wire

// ==== src/engine_csr_index.sv ====
// CSR index engine top level
`default_nettype none

module engine_csr_index import csr_index_pkg::*; (
    input  wire logic                 ap_clk,
    input  wire logic                 areset_csr_engine,
    input  wire logic                 response_valid_i,
    input  wire logic [PAYLOAD_W-1:0] response_payload_i,
    input  wire logic                 start_i,
    input  wire logic                 request_rd_en_i,
    output logic                      request_valid_o,
    output logic      [PAYLOAD_W-1:0] request_payload_o,
    input  wire logic                 engine_rd_en_i,
    output logic                      engine_valid_o,
    output logic      [PAYLOAD_W-1:0] engine_payload_o,
    output logic                      response_prog_full_o,
    output logic                      done_o
);

    // Registered inputs
    logic                 response_valid_q;
    logic [PAYLOAD_W-1:0] response_payload_q;
    logic                 start_q;
    logic                 request_rd_en_q;
    logic                 engine_rd_en_q;

    // Response path
    logic [PAYLOAD_W-1:0] resp_dout;
    logic                 resp_valid;
    logic                 resp_prog_full;
    logic                 resp_pop;
    response_word_t       resp_word;
    logic                 cfg_valid;
    cfg_word_t            cfg_word;
    logic                 gen_valid;
    data_word_t           gen_word;
    logic                 gen_accept;

    // Run fields
    logic [INDEX_W-1:0]   start_index;
    logic [INDEX_W-1:0]   index_count;
    logic [ADDR_W-1:0]    base_addr;
    logic                 config_ready;

    // Output paths
    logic                 req_push;
    logic [PAYLOAD_W-1:0] req_payload;
    logic [PAYLOAD_W-1:0] req_dout;
    logic                 req_empty;
    logic                 req_prog_full;
    logic                 req_pop;
    logic                 eng_push;
    logic [PAYLOAD_W-1:0] eng_payload;
    logic [PAYLOAD_W-1:0] eng_dout;
    logic                 eng_empty;
    logic                 eng_prog_full;
    logic                 eng_pop;
    logic                 gen_done;

    // ------------------------------
    // Input registers
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            response_valid_q <= 1'b0;
            start_q          <= 1'b0;
            request_rd_en_q  <= 1'b0;
            engine_rd_en_q   <= 1'b0;
        end else begin
            response_valid_q <= response_valid_i;
            start_q          <= start_i;
            request_rd_en_q  <= request_rd_en_i;
            engine_rd_en_q   <= engine_rd_en_i;
        end
    end

    always_ff @(posedge ap_clk) begin
        response_payload_q <= response_payload_i;
    end

    // ------------------------------
    // Output registers
    // ------------------------------
    // Valid strobes mark exactly the popped words
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            request_valid_o      <= 1'b0;
            engine_valid_o       <= 1'b0;
            response_prog_full_o <= 1'b0;
            done_o               <= 1'b1;
        end else begin
            request_valid_o      <= req_pop;
            engine_valid_o       <= eng_pop;
            response_prog_full_o <= resp_prog_full;
            done_o               <= gen_done;
        end
    end

    always_ff @(posedge ap_clk) begin
        request_payload_o <= req_dout;
        engine_payload_o  <= eng_dout;
    end

    assign req_pop   = !req_empty && request_rd_en_q;
    assign eng_pop   = !eng_empty && engine_rd_en_q;
    assign resp_word = resp_dout;

    // ------------------------------
    // FIFOs
    // ------------------------------
    packet_fifo #(.DEPTH(FIFO_DEPTH), .THRESH(PROG_THRESH)) u_response_fifo (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .wr_en_i(response_valid_q), .din_i(response_payload_q), .rd_en_i(resp_pop),
        .dout_o(resp_dout), .valid_o(resp_valid), .empty_o(), .full_o(),
        .prog_full_o(resp_prog_full)
    );

    packet_fifo #(.DEPTH(FIFO_DEPTH), .THRESH(PROG_THRESH)) u_request_fifo (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .wr_en_i(req_push), .din_i(req_payload), .rd_en_i(req_pop),
        .dout_o(req_dout), .valid_o(), .empty_o(req_empty), .full_o(),
        .prog_full_o(req_prog_full)
    );

    packet_fifo #(.DEPTH(FIFO_DEPTH), .THRESH(PROG_THRESH)) u_engine_fifo (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .wr_en_i(eng_push), .din_i(eng_payload), .rd_en_i(eng_pop),
        .dout_o(eng_dout), .valid_o(), .empty_o(eng_empty), .full_o(),
        .prog_full_o(eng_prog_full)
    );

    // ------------------------------
    // Routing, configuration, generation
    // ------------------------------
    response_router u_router (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .fifo_valid_i(resp_valid), .fifo_word_i(resp_word), .fifo_pop_o(resp_pop),
        .cfg_valid_o(cfg_valid), .cfg_word_o(cfg_word),
        .gen_valid_o(gen_valid), .gen_word_o(gen_word), .gen_accept_i(gen_accept)
    );

    csr_index_config u_config (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .cfg_valid_i(cfg_valid), .cfg_word_i(cfg_word),
        .start_index_o(start_index), .index_count_o(index_count),
        .base_addr_o(base_addr), .config_ready_o(config_ready)
    );

    csr_index_generator u_generator (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .start_i(start_q), .config_ready_i(config_ready),
        .start_index_i(start_index), .index_count_i(index_count), .base_addr_i(base_addr),
        .req_prog_full_i(req_prog_full), .req_push_o(req_push), .req_payload_o(req_payload),
        .gen_valid_i(gen_valid), .gen_word_i(gen_word), .gen_accept_o(gen_accept),
        .eng_prog_full_i(eng_prog_full), .eng_push_o(eng_push), .eng_payload_o(eng_payload),
        .done_o(gen_done)
    );

endmodule

`default_nettype wire

// ==== dv/tb_engine_csr_index.sv ====
// CSR index engine testbench
`default_nettype none

module tb_engine_csr_index import csr_index_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 5;
    localparam int SETTLE_CYCLES = 8;
    localparam int TOTAL_INDEXES = 6 + 0 + 40 + 40;
    localparam int WATCH_CYCLES  = TOTAL_INDEXES * 200;

    logic                 ap_clk             = 1'b0;
    logic                 areset_csr_engine  = 1'b1;
    logic                 response_valid_i   = 1'b0;
    logic [PAYLOAD_W-1:0] response_payload_i = '0;
    logic                 start_i            = 1'b0;
    logic                 request_rd_en_i    = 1'b0;
    logic                 engine_rd_en_i     = 1'b0;
    logic                 request_valid_o;
    logic [PAYLOAD_W-1:0] request_payload_o;
    logic                 engine_valid_o;
    logic [PAYLOAD_W-1:0] engine_payload_o;
    logic                 response_prog_full_o;
    logic                 done_o;

    // Expected outputs and words waiting to enter the response port
    logic [PAYLOAD_W-1:0] exp_req_q[$];
    logic [PAYLOAD_W-1:0] exp_eng_q[$];
    logic [PAYLOAD_W-1:0] pend_word_q[$];
    int                   pend_time_q[$];

    int unsigned        lcg_state     = 75;
    int                 cycle         = 0;
    int                 errors        = 0;
    int                 tests_run     = 0;
    int                 tests_failed  = 0;
    logic               back_pressure = 1'b0;
    int                 req_hold      = 0;
    int                 eng_hold      = 0;
    // Shadow copy of the run fields
    logic [INDEX_W-1:0] run_start     = '0;
    logic [INDEX_W-1:0] run_count     = '0;
    logic [ADDR_W-1:0]  run_base      = '0;

    engine_csr_index engine_csr_index_i (
        .ap_clk               (ap_clk),
        .areset_csr_engine    (areset_csr_engine),
        .response_valid_i     (response_valid_i),
        .response_payload_i   (response_payload_i),
        .start_i              (start_i),
        .request_rd_en_i      (request_rd_en_i),
        .request_valid_o      (request_valid_o),
        .request_payload_o    (request_payload_o),
        .engine_rd_en_i       (engine_rd_en_i),
        .engine_valid_o       (engine_valid_o),
        .engine_payload_o     (engine_payload_o),
        .response_prog_full_o (response_prog_full_o),
        .done_o               (done_o)
    );

    always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

    always @(posedge ap_clk) begin
        cycle <= cycle + 1;
    end

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function automatic logic [DATA_W-1:0] expected_data(input logic [INDEX_W-1:0] idx);
        return {idx[7:0], idx} ^ (DATA_W'(idx) * 32'h9E37_79B9);
    endfunction

    function automatic logic [ADDR_W-1:0] expected_addr(input logic [ADDR_W-1:0] base,
                                                        input logic [INDEX_W-1:0] start,
                                                        input int k);
        return base + (ADDR_W'(start) + ADDR_W'(k)) * ADDR_W'(WORD_BYTES);
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    // ------------------------------
    // Memory model and source
    // ------------------------------
    // Source pauses while the response FIFO reports prog_full
    always @(posedge ap_clk) begin
        if (!areset_csr_engine && pend_word_q.size() > 0 && pend_time_q[0] <= cycle &&
            !response_prog_full_o) begin
            response_valid_i   <= 1'b1;
            response_payload_i <= pend_word_q.pop_front();
            void'(pend_time_q.pop_front());
        end else begin
            response_valid_i <= 1'b0;
        end
    end

    // Long random stretches of mostly low rd_en
    always @(posedge ap_clk) begin
        if (!back_pressure) begin
            request_rd_en_i <= 1'b1;
            engine_rd_en_i  <= 1'b1;
        end else begin
            if (req_hold == 0) begin
                request_rd_en_i <= (next_rand() % 3) == 0;
                req_hold = 4 + int'(next_rand() % 29);
            end else begin
                req_hold--;
            end
            if (eng_hold == 0) begin
                engine_rd_en_i <= (next_rand() % 3) == 0;
                eng_hold = 4 + int'(next_rand() % 29);
            end else begin
                eng_hold--;
            end
        end
    end

    task automatic take_request(input logic [PAYLOAD_W-1:0] got);
        logic [INDEX_W-1:0] idx;
        idx = got[TAG_HI:TAG_LO];
        assert (exp_req_q.size() > 0) else begin
            $display("Request %0h at %0t ns arrived with none outstanding", got, $time);
            errors++;
        end
        if (exp_req_q.size() > 0) begin
            check_value("request_payload_o", exp_req_q.pop_front(), got);
            // Memory answers after 1 to 8 cycles
            pend_word_q.push_back({DEST_GENERATOR, 7'b0, idx, expected_data(idx)});
            pend_time_q.push_back(cycle + 1 + int'(next_rand() % 8));
        end
    endtask

    task automatic take_engine(input logic [PAYLOAD_W-1:0] got);
        assert (exp_eng_q.size() > 0) else begin
            $display("Engine packet %0h at %0t ns arrived with none outstanding", got, $time);
            errors++;
        end
        if (exp_eng_q.size() > 0) begin
            check_value("engine_payload_o", exp_eng_q.pop_front(), got);
        end
    endtask

    // Comparer samples outputs at the falling edge
    always @(negedge ap_clk) begin
        if (!areset_csr_engine && request_valid_o) begin
            take_request(request_payload_o);
        end
        if (!areset_csr_engine && engine_valid_o) begin
            take_engine(engine_payload_o);
        end
    end

    // ------------------------------
    // Stimulus tasks
    // ------------------------------
    task automatic send_config(input logic [2:0] field, input logic [DATA_W-1:0] value);
        pend_word_q.push_back({DEST_CONFIG, field, 28'b0, value});
        pend_time_q.push_back(cycle);
        case (field)
            CFG_START_INDEX: run_start = value[INDEX_W-1:0];
            CFG_INDEX_COUNT: run_count = value[INDEX_W-1:0];
            CFG_BASE_ADDR:   run_base  = value;
            default: begin
            end
        endcase
    endtask

    task automatic wait_config_settled();
        while (pend_word_q.size() != 0) begin
            @(posedge ap_clk);
        end
        // Input register, FIFO, router slot and config register
        repeat (SETTLE_CYCLES) @(posedge ap_clk);
    endtask

    task automatic pulse_start();
        @(posedge ap_clk);
        start_i <= 1'b1;
        @(posedge ap_clk);
        start_i <= 1'b0;
    endtask

    task automatic run_indexes(input logic extra_start);
        int                 k;
        logic [INDEX_W-1:0] idx;
        for (k = 0; k < int'(run_count); k++) begin
            idx = INDEX_W'(run_start + k);
            exp_req_q.push_back({8'h00, idx, expected_addr(run_base, run_start, k)});
            exp_eng_q.push_back({8'h00, idx, expected_data(idx)});
        end
        pulse_start();
        while (done_o) begin
            @(negedge ap_clk);
        end
        if (extra_start) begin
            repeat (3) @(posedge ap_clk);
            pulse_start();
        end
        while (!done_o) begin
            @(negedge ap_clk);
        end
        // Done only after every request went out and every response came back
        assert (exp_req_q.size() == 0 && pend_word_q.size() == 0) else begin
            $display("done_o rose at %0t ns before all responses were returned", $time);
            errors++;
        end
        while (exp_req_q.size() != 0 || exp_eng_q.size() != 0) begin
            @(negedge ap_clk);
        end
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        tests_run++;
        if (errors == errs_at_start) begin
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s (%0d errors)", name, errors - errs_at_start);
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin : main_sequence
        int errs_at_start;
        repeat (RESET_CYCLES) @(posedge ap_clk);
        areset_csr_engine <= 1'b0;

        errs_at_start = errors;
        @(negedge ap_clk);
        check_value("done_o", 64'(1'b1), 64'(done_o));
        check_value("request_valid_o", 64'(1'b0), 64'(request_valid_o));
        check_value("engine_valid_o", 64'(1'b0), 64'(engine_valid_o));
        check_value("response_prog_full_o", 64'(1'b0), 64'(response_prog_full_o));
        finish_test("reset state", errs_at_start);

        errs_at_start = errors;
        send_config(CFG_BASE_ADDR, 32'h0000_1000);
        send_config(CFG_INDEX_COUNT, 32'd6);
        send_config(CFG_START_INDEX, 32'd5);
        wait_config_settled();
        run_indexes(1'b0);
        finish_test("single run, fields out of order", errs_at_start);

        errs_at_start = errors;
        send_config(CFG_INDEX_COUNT, 32'd0);
        wait_config_settled();
        pulse_start();
        repeat (12) begin
            @(negedge ap_clk);
            check_value("done_o", 64'(1'b1), 64'(done_o));
        end
        finish_test("zero count keeps done high", errs_at_start);

        errs_at_start = errors;
        back_pressure = 1'b1;
        send_config(CFG_START_INDEX, 32'd100);
        send_config(CFG_INDEX_COUNT, 32'd40);
        send_config(CFG_BASE_ADDR, 32'h2000_0000);
        wait_config_settled();
        run_indexes(1'b0);
        back_pressure = 1'b0;
        finish_test("random back-pressure on both outputs", errs_at_start);

        // Only the base changes and start and count carry over
        errs_at_start = errors;
        send_config(CFG_BASE_ADDR, 32'h0040_0000);
        wait_config_settled();
        run_indexes(1'b1);
        repeat (20) @(negedge ap_clk);
        finish_test("rewritten field and start while running", errs_at_start);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCH_CYCLES * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d cycles", WATCH_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
src/csr_index_pkg.sv
src/packet_fifo.sv
src/response_router.sv
src/csr_index_config.sv
src/csr_index_generator.sv
src/engine_csr_index.sv
dv/tb_engine_csr_index.sv

// ==== Makefile ====
TOP := tb_engine_csr_index

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
		-f project.f -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir
